// ==== mem_pkg.sv ====
package mem_pkg;

	//////////////////////////////
	// Data memory geometry
	//////////////////////////////
	localparam int XLEN        = 32;               // Datapath width
	localparam int BYTE_W      = 8;                // One bank lane
	localparam int HALF_W      = 16;               // Halfword width
	localparam int LANES       = XLEN / BYTE_W;    // Four byte banks
	localparam int LANE_W      = 2;                // Lane select bits in the address
	localparam int ADDR_W      = 15;               // 32 KB byte address space
	localparam int BANK_ADDR_W = ADDR_W - LANE_W;  // 13-bit row address
	localparam int BANK_DEPTH  = 1 << BANK_ADDR_W; // 8192 rows per bank

	// Byte address as seen by the data memory
	// Bits 1:0 pick the lane, upper bits pick the row
	typedef logic [ADDR_W-1:0] mem_addr_t;

	// Row address shared by all four banks
	typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

	//////////////////////////////
	// Load/store access type
	//////////////////////////////
	// Same encoding as funct3 of the RV32I load and store opcodes
	typedef enum logic [2:0] {
		MT_BYTE   = 3'b000, // LB / SB
		MT_HALF   = 3'b001, // LH / SH
		MT_WORD   = 3'b010, // LW / SW
		MT_BYTE_U = 3'b100, // LBU with no store form
		MT_HALF_U = 3'b101  // LHU with no store form
	} mem_type_e;

	// Codes 011, 110 and 111 are not decoded
	// Stores with them write nothing and loads return zero

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

	import mem_pkg::mem_type_e;

	localparam int RF_ADDR_W = 5; // 32 architectural registers

	//////////////////////////////
	// EX/MEM pipeline register
	//////////////////////////////
	typedef struct packed {
		logic [mem_pkg::XLEN-1:0] result;     // ALU result that doubles as the address
		logic [mem_pkg::XLEN-1:0] store_data; // rs2 value for stores
		logic                     mem_write;  // Store
		logic                     mem_read;   // Load
		mem_type_e                mem_type;   // funct3 of the access
		logic                     reg_write;  // Instruction writes rd
		logic [RF_ADDR_W-1:0]     rd;         // Destination register
	} ex_mem_t;

	//////////////////////////////
	// MEM/WB pipeline register
	//////////////////////////////
	// Writeback request toward the register file
	typedef struct packed {
		logic                     reg_write;
		logic [RF_ADDR_W-1:0]     rd;
		logic [mem_pkg::XLEN-1:0] wb_data;    // Load value or ALU result
	} mem_wb_t;

endpackage

// ==== dmem8.sv ====
`timescale 1ns/1ns

module dmem8 (
	input  logic                       clk,
	input  mem_pkg::bank_addr_t        addr,
	input  logic                       re,
	input  logic                       we,
	input  logic [mem_pkg::BYTE_W-1:0] wdata,
	output logic [mem_pkg::BYTE_W-1:0] rdata
);

	import mem_pkg::*;

	// One byte lane of the data memory
	logic [BYTE_W-1:0] mem [0:BANK_DEPTH-1];

	//////////////////////////////
	// Write port
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata; // Only lanes picked by the store
		end
	end

	//////////////////////////////
	// Read port
	//////////////////////////////
	// Registered read so data shows up the cycle after re
	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[addr];
		end
		// Otherwise rdata holds the last byte read
	end

endmodule

// ==== memory.sv ====
`timescale 1ns/1ns

module memory (
	input  logic                     clk,
	input  logic                     rst_n,
	input  mem_pkg::mem_addr_t       addr,
	input  logic                     mem_write,
	input  logic                     mem_read,
	input  logic [mem_pkg::XLEN-1:0] store_data,
	input  mem_pkg::mem_type_e       mem_type,
	output logic [mem_pkg::XLEN-1:0] load_data
);

	import mem_pkg::*;

	// Format of the load in flight until its data returns
	typedef struct packed {
		mem_type_e         mtype;
		logic [LANE_W-1:0] lane;
	} ld_fmt_t;

	bank_addr_t          row;       // Same row in every bank
	logic [LANE_W-1:0]   lane;      // Low address bits
	logic [LANES-1:0]    lane_sel;  // Lanes touched by this access
	logic                store_ok;  // Type is a legal store
	logic [LANES-1:0]    bank_re;
	logic [LANES-1:0]    bank_we;
	logic [XLEN-1:0]     wdata_bus; // Store bytes already in lane position
	logic [XLEN-1:0]     rdata_bus; // {bank3, bank2, bank1, bank0}
	ld_fmt_t             fmt_q;
	logic [BYTE_W-1:0]   ld_byte;
	logic [HALF_W-1:0]   ld_half;

	assign row  = addr[ADDR_W-1:LANE_W];
	assign lane = addr[LANE_W-1:0];

	//////////////////////////////
	// Lane decode
	//////////////////////////////
	always_comb begin
		lane_sel = '0;
		store_ok = 1'b0;
		case (mem_type)
			MT_BYTE: begin
				lane_sel[lane] = 1'b1; // Single lane
				store_ok       = 1'b1;
			end
			MT_BYTE_U: begin
				lane_sel[lane] = 1'b1; // Load only
			end
			MT_HALF: begin
				lane_sel = lane[1] ? 4'b1100 : 4'b0011; // Bit 0 ignored
				store_ok = 1'b1;
			end
			MT_HALF_U: begin
				lane_sel = lane[1] ? 4'b1100 : 4'b0011;
			end
			MT_WORD: begin
				lane_sel = '1; // Whole row
				store_ok = 1'b1;
			end
			default: begin
				lane_sel = '0; // Unsupported code touches nothing
			end
		endcase
	end

	// Enables gated by the request itself
	assign bank_re = lane_sel & {LANES{mem_read}};
	assign bank_we = lane_sel & {LANES{mem_write & store_ok}};

	//////////////////////////////
	// Store byte steering
	//////////////////////////////
	// Replicate the low bytes so every candidate lane sees the right value
	always_comb begin
		case (mem_type)
			MT_WORD: wdata_bus = store_data;
			MT_HALF: wdata_bus = {2{store_data[HALF_W-1:0]}}; // Low or high half
			default: wdata_bus = {LANES{store_data[BYTE_W-1:0]}};
		endcase
	end

	//////////////////////////////
	// Byte banks
	//////////////////////////////
	for (genvar i = 0; i < LANES; i++) begin : g_bank
		dmem8 u_bank (
			.clk   (clk),
			.addr  (row),
			.re    (bank_re[i]),
			.we    (bank_we[i]),
			.wdata (wdata_bus[i*BYTE_W +: BYTE_W]),
			.rdata (rdata_bus[i*BYTE_W +: BYTE_W])
		);
	end

	//////////////////////////////
	// Load format register
	//////////////////////////////
	// Captured with the bank read so the extend logic matches the data
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fmt_q.mtype <= MT_WORD;
			fmt_q.lane  <= '0;
		end else if (mem_read) begin
			fmt_q.mtype <= mem_type;
			fmt_q.lane  <= lane;
		end
	end

	//////////////////////////////
	// Load extension
	//////////////////////////////
	// Pick the lane(s) of the returned row
	assign ld_byte = rdata_bus[{fmt_q.lane, 3'b000} +: BYTE_W];
	assign ld_half = fmt_q.lane[1] ? rdata_bus[XLEN-1:HALF_W] : rdata_bus[HALF_W-1:0];

	always_comb begin
		case (fmt_q.mtype)
			MT_BYTE:   load_data = {{(XLEN-BYTE_W){ld_byte[BYTE_W-1]}}, ld_byte}; // LB
			MT_BYTE_U: load_data = {{(XLEN-BYTE_W){1'b0}}, ld_byte};             // LBU
			MT_HALF:   load_data = {{(XLEN-HALF_W){ld_half[HALF_W-1]}}, ld_half}; // LH
			MT_HALF_U: load_data = {{(XLEN-HALF_W){1'b0}}, ld_half};             // LHU
			MT_WORD:   load_data = rdata_bus;                                    // LW
			default:   load_data = '0; // Unsupported code reads as zero
		endcase
	end

endmodule

// ==== mem_wb_stage.sv ====
`timescale 1ns/1ns

module mem_wb_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	input  pipe_pkg::ex_mem_t        ex_mem,
	input  logic [mem_pkg::XLEN-1:0] load_data,
	output pipe_pkg::mem_wb_t        mem_wb
);

	import mem_pkg::*;
	import pipe_pkg::*;

	logic                 reg_write_q; // Cleared by reset
	logic                 mem_read_q;  // Picks load data over result
	logic [RF_ADDR_W-1:0] rd_q;
	logic [XLEN-1:0]      result_q;

	//////////////////////////////
	// Control register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			reg_write_q <= 1'b0;
			mem_read_q  <= 1'b0;
		end else begin
			reg_write_q <= ex_mem.reg_write;
			mem_read_q  <= ex_mem.mem_read;
		end
	end

	// Payload follows the instruction every cycle
	always_ff @(posedge clk) begin
		rd_q     <= ex_mem.rd;
		result_q <= ex_mem.result;
	end

	//////////////////////////////
	// Writeback data select
	//////////////////////////////
	// Load value arrives in the same cycle as the registered control
	always_comb begin
		mem_wb.reg_write = reg_write_q;
		mem_wb.rd        = rd_q;
		if (mem_read_q) begin
			mem_wb.wb_data = load_data; // Extended load
		end else begin
			mem_wb.wb_data = result_q;  // ALU result passes through
		end
	end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  pipe_pkg::ex_mem_t ex_mem,
	output pipe_pkg::mem_wb_t mem_wb
);

	import mem_pkg::*;

	mem_addr_t       mem_addr;  // Byte address into data memory
	logic [XLEN-1:0] load_data; // Valid the cycle after a load

	// Upper result bits are outside the memory and simply dropped
	assign mem_addr = ex_mem.result[ADDR_W-1:0];

	//////////////////////////////
	// Data memory
	//////////////////////////////
	memory u_memory (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (mem_addr),
		.mem_write  (ex_mem.mem_write),
		.mem_read   (ex_mem.mem_read),
		.store_data (ex_mem.store_data),
		.mem_type   (ex_mem.mem_type),
		.load_data  (load_data)
	);

	//////////////////////////////
	// MEM/WB register
	//////////////////////////////
	// Lines up rd and control with the load data one cycle later
	mem_wb_stage u_mem_wb (
		.clk       (clk),
		.rst_n     (rst_n),
		.ex_mem    (ex_mem),
		.load_data (load_data),
		.mem_wb    (mem_wb)
	);

endmodule

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ns

module tb_mem_stage;

	import mem_pkg::*;
	import pipe_pkg::*;

	localparam int        CLK_PERIOD  = 8;
	localparam int        RST_CYCLES  = 10;
	localparam mem_addr_t WIN_BASE    = 15'h5a40; // Window of 64 words
	localparam int        WIN_WORDS   = 64;
	localparam int        N_RT        = 32;       // Word round trips
	localparam int        N_MIX       = 100;      // Request pairs in the mix
	localparam int        N_REQ       = 5 + WIN_WORDS + 2 * N_RT + 24 + 34 + 2 * N_MIX + 9;
	localparam int        WATCHDOG_NS = N_REQ * CLK_PERIOD * 2 + RST_CYCLES * CLK_PERIOD;

	logic    clk;
	logic    rst_n;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	logic [7:0] ref_mem [0:(1 << ADDR_W) - 1]; // Byte image of the data memory
	mem_wb_t    exp_q [$];                      // Expected results in issue order
	time        exp_time_q [$];                 // Issue time of each entry
	int         seed = 32'h17ec;
	int         errors;
	int         checks;
	int         err_start;
	int         chk_start;
	string      cur_test;
	mem_type_e  load_types [5] = '{MT_BYTE, MT_HALF, MT_WORD, MT_BYTE_U, MT_HALF_U};
	logic [2:0] bad_codes [3] = '{3'b011, 3'b110, 3'b111};

	mem_stage UUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic mem_wb_t ref_step(input ex_mem_t req);
		mem_addr_t   a;
		mem_addr_t   hb;
		mem_addr_t   wb;
		logic [31:0] ld;
		mem_wb_t     res;
		a  = req.result[ADDR_W-1:0];
		hb = {a[ADDR_W-1:1], 1'b0};  // Halfword base ignoring bit 0
		wb = {a[ADDR_W-1:2], 2'b00}; // Word base
		if (req.mem_write) begin
			case (req.mem_type)
				MT_BYTE: ref_mem[a] = req.store_data[7:0];
				MT_HALF: begin
					ref_mem[hb]         = req.store_data[7:0];
					ref_mem[hb + 15'd1] = req.store_data[15:8];
				end
				MT_WORD: begin
					for (int i = 0; i < 4; i++) begin
						ref_mem[wb + 15'(i)] = req.store_data[i*8 +: 8];
					end
				end
				default: ; // Other codes leave memory alone
			endcase
		end
		case (req.mem_type)
			MT_BYTE:   ld = {{24{ref_mem[a][7]}}, ref_mem[a]};
			MT_BYTE_U: ld = {24'd0, ref_mem[a]};
			MT_HALF:   ld = {{16{ref_mem[hb + 15'd1][7]}}, ref_mem[hb + 15'd1], ref_mem[hb]};
			MT_HALF_U: ld = {16'd0, ref_mem[hb + 15'd1], ref_mem[hb]};
			MT_WORD:   ld = {ref_mem[wb + 15'd3], ref_mem[wb + 15'd2],
				ref_mem[wb + 15'd1], ref_mem[wb]};
			default:   ld = '0;
		endcase
		res.reg_write = req.reg_write;
		res.rd        = req.rd;
		res.wb_data   = req.mem_read ? ld : req.result;
		return res;
	endfunction

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////
	function automatic ex_mem_t idle_req();
		ex_mem_t r;
		r          = '0;
		r.mem_type = MT_WORD;
		return r;
	endfunction

	function automatic ex_mem_t make_req(input mem_addr_t a, input logic [31:0] sd,
		input logic wr, input logic rd_en, input mem_type_e t);
		ex_mem_t     r;
		logic [31:0] hi;
		hi           = $random(seed);
		r.result     = {hi[31:ADDR_W], a}; // Upper bits never reach the memory
		r.store_data = sd;
		r.mem_write  = wr;
		r.mem_read   = rd_en;
		r.mem_type   = t;
		r.reg_write  = rd_en; // Loads write back, stores do not
		r.rd         = hi[4:0];
		return r;
	endfunction

	function automatic mem_addr_t rand_addr();
		logic [7:0] off;
		off = $random(seed);
		return WIN_BASE + 15'(off);
	endfunction

	function automatic mem_addr_t rand_word_addr();
		logic [7:0] off;
		off = $random(seed);
		return WIN_BASE + 15'({off[7:2], 2'b00});
	endfunction

	// Initial word contents where every address bit shows up
	function automatic logic [31:0] fill_word(input mem_addr_t a);
		return {1'b0, a, a ^ 15'h2b5d, 1'b1};
	endfunction

	task automatic issue(input ex_mem_t req);
		@(negedge clk);
		ex_mem = req;
		exp_q.push_back(ref_step(req));
		exp_time_q.push_back($time);
	endtask

	task automatic store(input mem_addr_t a, input logic [31:0] d, input mem_type_e t);
		issue(make_req(a, d, 1'b1, 1'b0, t));
	endtask

	task automatic load(input mem_addr_t a, input mem_type_e t);
		issue(make_req(a, $random(seed), 1'b0, 1'b1, t));
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		err_start = errors;
		chk_start = checks;
	endtask

	// Idle the bus and wait until every result is compared
	task automatic end_test();
		@(negedge clk);
		ex_mem = idle_req();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		$display("Test %-12s done: %0d checks, %0d errors", cur_test,
			checks - chk_start, errors - err_start);
	endtask

	//////////////////////////////
	// Compare process
	//////////////////////////////
	always @(negedge clk) begin : compare
		mem_wb_t want;
		if (exp_q.size() != 0 && exp_time_q[0] < $time) begin // Issued an edge ago
			want = exp_q.pop_front();
			void'(exp_time_q.pop_front());
			checks++;
			assert (mem_wb === want) else begin
				$display("ERR %0t: %s rd %0d got we=%b data=%h, expected we=%b data=%h",
					$time, cur_test, want.rd, mem_wb.reg_write, mem_wb.wb_data,
					want.reg_write, want.wb_data);
				errors++;
			end
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin : main
		mem_addr_t a;
		mem_type_e bad;
		ex_mem_t   r;
		int        kind;
		int        idx;
		logic [31:0] d;
		clk              = 1'b0;
		rst_n            = 1'b0;
		ex_mem           = idle_req();
		ex_mem.reg_write = 1'b1; // Held off by reset
		ex_mem.rd        = 5'd7;

		start_test("reset");
		repeat (RST_CYCLES) begin
			@(negedge clk);
			checks++;
			assert (mem_wb.reg_write === 1'b0) else begin
				$display("ERR %0t: reg_write high during reset", $time);
				errors++;
			end
		end
		rst_n  = 1'b1;
		ex_mem = idle_req();
		issue(idle_req()); // Still low right after reset
		for (int i = 0; i < 4; i++) begin
			r            = idle_req();
			r.result     = $random(seed);
			r.store_data = $random(seed);
			r.reg_write  = (i != 2);
			r.rd         = $random(seed);
			issue(r);   // ALU result passes through
		end
		end_test();

		start_test("fill");
		for (int i = 0; i < WIN_WORDS; i++) begin
			a = WIN_BASE + 15'(4 * i);
			store(a, fill_word(a), MT_WORD);
		end
		end_test();

		start_test("word_rt");
		for (int i = 0; i < N_RT; i++) begin
			a = rand_word_addr();
			store(a, $random(seed), MT_WORD);
			load(a, MT_WORD);
		end
		end_test();

		start_test("subword");
		for (int k = 0; k < 2; k++) begin
			a = rand_word_addr();
			for (int lane = 0; lane < 4; lane++) begin
				store(a + 15'(lane), $random(seed), MT_BYTE);
				load(a, MT_WORD);
			end
			for (int h = 0; h < 2; h++) begin
				d = $random(seed);
				store(a + 15'(2 * h) + 15'(d[31]), d, MT_HALF); // Odd address too
				load(a, MT_WORD);
			end
		end
		end_test();

		start_test("extend");
		a = rand_word_addr();
		for (int v = 0; v < 2; v++) begin
			store(a, (v != 0) ? 32'hc4e9_a0f7 : 32'h7f3a_5c21, MT_WORD); // Top bits set / clear
			for (int lane = 0; lane < 4; lane++) begin
				load(a + 15'(lane), MT_BYTE);
				load(a + 15'(lane), MT_BYTE_U);
				load(a + 15'(lane), MT_HALF);
				load(a + 15'(lane), MT_HALF_U);
			end
		end
		end_test();

		start_test("mix");
		for (int i = 0; i < N_MIX; i++) begin
			a    = rand_addr();
			kind = $unsigned($random(seed)) % 3;
			idx  = $unsigned($random(seed)) % 5;
			case (kind)
				0: store(a, $random(seed), load_types[idx]); // Unsigned types write nothing
				1: load(a, load_types[idx]);
				default: begin
					r        = idle_req();
					r.result = $random(seed);
					r.rd     = $random(seed);
					r.reg_write = 1'b1;
					issue(r);
				end
			endcase
			idx = $unsigned($random(seed)) % 5;
			load(a, load_types[idx]); // Same address in the next cycle
		end
		end_test();

		start_test("unsupported");
		for (int i = 0; i < 3; i++) begin
			bad = mem_type_e'(bad_codes[i]);
			a   = rand_word_addr();
			store(a, $random(seed), bad);
			load(a, MT_WORD);  // Word unchanged
			load(a + 15'(i), bad); // Reads as zero
		end
		end_test();

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	//////////////////////////////
	// Watchdog
	//////////////////////////////
	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Simulation timed out after %0d ns", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== src.f ====
mem_pkg.sv
pipe_pkg.sv
dmem8.sv
memory.sv
mem_wb_stage.sv
mem_stage.sv
tb_mem_stage.sv
